/* logic/fft_mag_cfg.svh */
`ifndef FFT_MAG_CFG_SVH
`define FFT_MAG_CFG_SVH

// points per frame, must stay a power of two
`define FFT_TRANSFORM_LEN 32'd1024

// width of one real or imaginary part
`define FFT_SAMPLE_W 32

// bins kept per frame, also the queue depth
`define FFT_HALF_LEN (`FFT_TRANSFORM_LEN / 2)

// index bits for a bin below FFT_HALF_LEN
`define FFT_IDX_W $clog2(`FFT_HALF_LEN)

`endif

/* logic/fft_mag_pkg.sv */
`include "fft_mag_cfg.svh"

package fft_mag_pkg;

    typedef logic signed [`FFT_SAMPLE_W-1:0]   sample_t;   // one fft component
    typedef logic        [2*`FFT_SAMPLE_W-1:0] power_t;    // re^2 + im^2
    typedef logic        [`FFT_SAMPLE_W-1:0]   mag_t;      // floor of sqrt(power)
    typedef logic        [`FFT_IDX_W-1:0]      bin_idx_t;  // index in kept half

    // one beat of streamed fft output
    typedef struct packed {
        sample_t re;
        sample_t im;
        logic    valid;
        logic    sop;
        logic    eop;
    } fft_beat_t;

    // power with its flags, all on the same pipeline stage
    typedef struct packed {
        power_t power;
        logic   valid;
        logic   sop;
    } power_beat_t;

    typedef struct packed {
        bin_idx_t index;
        power_t   power;
    } queue_entry_t;

    typedef struct packed {
        mag_t     mag;
        bin_idx_t index;
    } mag_result_t;

    typedef enum logic [1:0] {
        GATE_IDLE,
        GATE_ARMED,     // waiting for sop
        GATE_CAPTURE,
        GATE_DONE
    } gate_state_t;

endpackage

/* logic/bin_power.sv */
`timescale 1ns/10ps

module bin_power (
    input  logic                     clk,
    input  logic                     rst_n,
    input  fft_mag_pkg::fft_beat_t   beat,
    output fft_mag_pkg::power_beat_t pbeat
);
    import fft_mag_pkg::*;

    localparam int unsigned SIGN_BIT = $bits(sample_t) - 1;

    mag_t       abs_re;
    mag_t       abs_im;
    power_t     power_q;
    logic [1:0] valid_d;   // one flop per pipeline stage
    logic [1:0] sop_d;

    // stage one, magnitude of each component
    always_ff @(posedge clk) begin
        if (beat.re[SIGN_BIT]) begin
            abs_re <= mag_t'(~beat.re + 1'b1);
        end else begin
            abs_re <= mag_t'(beat.re);
        end
        if (beat.im[SIGN_BIT]) begin
            abs_im <= mag_t'(~beat.im + 1'b1);
        end else begin
            abs_im <= mag_t'(beat.im);
        end
    end

    // stage two, sum of squares at full width
    always_ff @(posedge clk) begin
        power_q <= power_t'(abs_re) * power_t'(abs_re) +
                   power_t'(abs_im) * power_t'(abs_im);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_d <= '0;
            sop_d   <= '0;
        end else begin
            valid_d <= {valid_d[0], beat.valid};
            sop_d   <= {sop_d[0], beat.sop};
        end
    end

    assign pbeat = '{power: power_q, valid: valid_d[1], sop: sop_d[1]};

    // end of frame only on a real beat
    a_eop_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n) beat.eop |-> beat.valid
    );

endmodule

/* logic/half_frame_gate.sv */
`timescale 1ns/10ps
`include "fft_mag_cfg.svh"

module half_frame_gate (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  pbeat_valid,
    input  logic                  pbeat_sop,
    output logic                  keep,
    output fft_mag_pkg::bin_idx_t bin_idx
);
    import fft_mag_pkg::*;

    localparam bin_idx_t LAST_IDX = bin_idx_t'(`FFT_HALF_LEN - 1);

    gate_state_t state;
    bin_idx_t    cnt;         // bins kept so far in this frame
    logic        first_hit;
    logic        last_keep;

    // first bin of the frame, sop seen while armed
    assign first_hit = (state == GATE_ARMED) && pbeat_valid && pbeat_sop;

    assign keep      = first_hit || ((state == GATE_CAPTURE) && pbeat_valid);
    assign last_keep = keep && (cnt == LAST_IDX);
    assign bin_idx   = cnt;   // zero while armed

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= GATE_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                GATE_IDLE: begin
                    if (start) begin
                        state <= GATE_ARMED;
                    end
                end
                GATE_ARMED, GATE_CAPTURE: begin
                    // start is ignored here, capture runs to the half frame
                    if (keep) begin
                        if (last_keep) begin
                            state <= GATE_DONE;
                            cnt   <= '0;
                        end else begin
                            state <= GATE_CAPTURE;
                            cnt   <= cnt + 1'b1;
                        end
                    end
                end
                GATE_DONE: begin
                    state <= GATE_IDLE;   // one cycle only
                end
                default: begin
                    state <= GATE_IDLE;
                end
            endcase
        end
    end

    // index restarts at zero on sop and only runs inside a capture
    a_keep_in_window: assert property (
        @(posedge clk) disable iff (!rst_n)
        keep |-> ((state == GATE_ARMED) && pbeat_sop && (cnt == '0)) ||
                 ((state == GATE_CAPTURE) && (cnt != '0))
    );

endmodule

/* logic/mag_queue.sv */
`timescale 1ns/10ps
`include "fft_mag_cfg.svh"

module mag_queue (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      wr,
    input  fft_mag_pkg::queue_entry_t wr_entry,
    input  logic                      root_busy,
    output logic                      root_start,
    output fft_mag_pkg::queue_entry_t rd_entry,
    output logic                      overflow
);
    import fft_mag_pkg::*;

    localparam int unsigned DEPTH = `FFT_HALF_LEN;

    queue_entry_t        mem [DEPTH];
    bin_idx_t            wr_ptr;   // wraps at DEPTH on its own
    bin_idx_t            rd_ptr;
    logic [`FFT_IDX_W:0] count;
    logic                empty;
    logic                full;
    logic                push;
    logic                busy_d;

    assign empty = (count == '0);
    assign full  = (count == DEPTH);
    assign push  = wr && !full;   // writes into a full queue are dropped

    // head entry goes straight to the root unit
    assign rd_entry = mem[rd_ptr];

    // busy_d blocks the cycle where busy has just fallen
    assign root_start = !empty && !root_busy && !busy_d;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_entry;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            busy_d   <= 1'b0;
            overflow <= 1'b0;
        end else begin
            busy_d <= root_busy;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (root_start) begin
                rd_ptr <= rd_ptr + 1'b1;   // pop with the start pulse
            end
            if (wr && full) begin
                overflow <= 1'b1;   // sticky until reset
            end
            case ({push, root_start})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a pop from an empty queue would wrap the count past DEPTH
    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        (count <= DEPTH) && (bin_idx_t'(wr_ptr - rd_ptr) == bin_idx_t'(count))
    );

    // start only to an idle root, which then goes busy
    a_start_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        root_start |-> !root_busy ##1 root_busy
    );

endmodule

/* logic/isqrt_seq.sv */
`timescale 1ns/10ps
`include "fft_mag_cfg.svh"

module isqrt_seq (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  fft_mag_pkg::power_t      radicand,
    input  fft_mag_pkg::bin_idx_t    tag,
    output logic                     busy,
    output logic                     done,
    output fft_mag_pkg::mag_result_t result
);
    import fft_mag_pkg::*;

    localparam int unsigned W      = `FFT_SAMPLE_W;
    localparam int unsigned STEP_W = $clog2(W);

    power_t            rad;      // radicand, top two bits consumed per step
    logic [W+1:0]      rem;      // signed partial remainder
    logic [W+1:0]      rem_sh;
    logic [W+1:0]      rem_nx;
    mag_t              root;
    bin_idx_t          tag_q;
    logic [STEP_W-1:0] step;

    assign rem_sh = {rem[W-1:0], rad[2*W-1 -: 2]};

    // non-restoring step, sign of the old remainder picks add or subtract
    always_comb begin
        if (rem[W+1]) begin
            rem_nx = rem_sh + {root, 2'b11};
        end else begin
            rem_nx = rem_sh - {root, 2'b01};
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rad   <= radicand;
            rem   <= '0;
            root  <= '0;
            tag_q <= tag;   // travels with the result
        end else if (busy) begin
            rad  <= rad << 2;
            rem  <= rem_nx;
            root <= {root[W-2:0], ~rem_nx[W+1]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == STEP_W'(W - 1)) begin
                    busy <= 1'b0;   // last result bit settles now
                    done <= 1'b1;
                end
            end
        end
    end

    assign result = '{mag: root, index: tag_q};

    // no start while running, nor in the result cycle
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n) start |-> !busy && !done
    );

endmodule

/* logic/fft_magnitude_unit.sv */
`timescale 1ns/10ps

module fft_magnitude_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  fft_mag_pkg::fft_beat_t   beat,
    input  logic                     start,
    output fft_mag_pkg::mag_result_t result,
    output logic                     result_valid,
    output logic                     root_busy,
    output logic                     overflow
);
    import fft_mag_pkg::*;

    power_beat_t  pbeat;
    logic         keep;
    bin_idx_t     bin_idx;
    queue_entry_t wr_entry;
    queue_entry_t rd_entry;
    logic         root_start;

    assign wr_entry = '{index: bin_idx, power: pbeat.power};

    bin_power bin_power_i (
        .clk   (clk),
        .rst_n (rst_n),
        .beat  (beat),
        .pbeat (pbeat)
    );

    // decides on the aligned beat, same stage as the power
    half_frame_gate half_frame_gate_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .pbeat_valid (pbeat.valid),
        .pbeat_sop   (pbeat.sop),
        .keep        (keep),
        .bin_idx     (bin_idx)
    );

    mag_queue mag_queue_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr         (keep),
        .wr_entry   (wr_entry),
        .root_busy  (root_busy),
        .root_start (root_start),
        .rd_entry   (rd_entry),
        .overflow   (overflow)
    );

    isqrt_seq isqrt_seq_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (root_start),
        .radicand (rd_entry.power),
        .tag      (rd_entry.index),
        .busy     (root_busy),
        .done     (result_valid),
        .result   (result)
    );

endmodule

/* testbench/fft_mag_checker.sv */
`timescale 1ns/10ps
`include "fft_mag_cfg.svh"

module fft_mag_checker (
    input  logic                     clk,
    input  logic                     rst_n,
    input  fft_mag_pkg::fft_beat_t   beat,
    input  logic                     start,
    input  fft_mag_pkg::mag_result_t result,
    input  logic                     result_valid,
    input  logic                     root_busy,
    input  logic                     overflow,
    output int                       pending
);
    import fft_mag_pkg::*;

    localparam int W    = `FFT_SAMPLE_W;
    localparam int HALF = `FFT_HALF_LEN;

    mag_result_t expect_q[$];   // predicted results, oldest first
    fft_beat_t   dly [2];       // input beats delayed to the power stage
    fft_beat_t   aligned;
    mag_result_t exp_r;
    gate_state_t gstate;
    int          model_idx;     // valid beats kept in this frame
    logic        keep_m;
    logic        overflow_seen = 1'b0;
    string       test_name = "reset";
    int          test_results;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          total_results;
    int          total_errors;

    function automatic power_t sum_of_squares(input sample_t re, input sample_t im);
        logic signed [2*W-1:0] re_x;
        logic signed [2*W-1:0] im_x;
        power_t                a_re;
        power_t                a_im;
        re_x = re;   // sign extended
        im_x = im;
        a_re = (re_x < 0) ? power_t'(-re_x) : power_t'(re_x);
        a_im = (im_x < 0) ? power_t'(-im_x) : power_t'(im_x);
        return a_re * a_re + a_im * a_im;
    endfunction

    // largest r with r*r <= p, one bit at a time from the top
    function automatic mag_t floor_sqrt(input power_t p);
        power_t r;
        power_t cand;
        r = '0;
        for (int b = W - 1; b >= 0; b--) begin
            cand = r | (power_t'(1) << b);
            if (cand * cand <= p) begin
                r = cand;
            end
        end
        return mag_t'(r);
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        $display("FAIL %s: %s expected %0d actual %0d", test_name, what, exp_v, act_v);
        test_errors++;
        total_errors++;
    endtask

    task automatic report_problem(input string what);
        $display("ERROR %s: %s", test_name, what);
        test_errors++;
        total_errors++;
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        test_results = 0;
        test_errors  = 0;
    endtask

    task automatic finish_test(input int exp_count);
        if (test_results != exp_count) begin
            report_mismatch("result count", exp_count, test_results);
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s passed, %0d results", test_name, test_results);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic summary(output int errors);
        test_name = "end of run";
        if (expect_q.size() != 0) begin
            report_problem($sformatf("%0d predicted results never arrived", expect_q.size()));
        end
        $display("summary: %0d tests, %0d passed, %0d failed, %0d results, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, total_results,
                 total_errors);
        errors = total_errors;
    endtask

    task automatic check_result();
        test_results++;
        total_results++;
        if (root_busy) begin
            report_problem("result_valid came while root_busy was still high");
        end
        if (expect_q.size() == 0) begin
            report_problem("a result arrived although none was predicted");
        end else begin
            exp_r = expect_q.pop_front();
            if (result.index != exp_r.index) begin
                report_mismatch("bin index", exp_r.index, result.index);
            end
            if (result.mag != exp_r.mag) begin
                report_mismatch($sformatf("bin %0d magnitude", exp_r.index),
                                exp_r.mag, result.mag);
            end
        end
    endtask

    // gate rule on the beat two cycles back, start taken as is
    task automatic step_gate();
        keep_m = 1'b0;
        case (gstate)
            GATE_IDLE:    if (start) gstate = GATE_ARMED;
            GATE_ARMED:   keep_m = aligned.valid && aligned.sop;
            GATE_CAPTURE: keep_m = aligned.valid;
            default:      gstate = GATE_IDLE;
        endcase
        if (keep_m) begin
            exp_r.mag   = floor_sqrt(sum_of_squares(aligned.re, aligned.im));
            exp_r.index = bin_idx_t'(model_idx);
            expect_q.push_back(exp_r);
            if (model_idx == HALF - 1) begin
                gstate    = GATE_DONE;
                model_idx = 0;
            end else begin
                gstate    = GATE_CAPTURE;
                model_idx = model_idx + 1;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            dly[0]    = '0;
            dly[1]    = '0;
            gstate    = GATE_IDLE;
            model_idx = 0;
        end else begin
            if (result_valid) begin
                check_result();
            end
            if (overflow && !overflow_seen) begin
                overflow_seen = 1'b1;
                report_problem("overflow went high, the queue was written while full");
            end
            aligned = dly[1];
            dly[1]  = dly[0];
            dly[0]  = beat;
            step_gate();
        end
        pending = expect_q.size();
    end

endmodule

/* testbench/fft_magnitude_unit_tb.sv */
`timescale 1ns/10ps
`include "fft_mag_cfg.svh"

module fft_magnitude_unit_tb;
    import fft_mag_pkg::*;

    localparam int LEN        = `FFT_TRANSFORM_LEN;
    localparam int HALF       = `FFT_HALF_LEN;
    localparam int W          = `FFT_SAMPLE_W;
    localparam int NUM_FRAMES = 7;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * (HALF * (W + 2) + LEN * 2) + 20000;

    localparam sample_t S_MIN = {1'b1, {(W-1){1'b0}}};
    localparam sample_t S_MAX = {1'b0, {(W-1){1'b1}}};

    logic        clk;
    logic        rst_n;
    fft_beat_t   beat;
    logic        start;
    mag_result_t result;
    logic        result_valid;
    logic        root_busy;
    logic        overflow;
    int          pending;   // predictions not yet matched
    int          errors;

    fft_magnitude_unit fft_magnitude_unit_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .beat         (beat),
        .start        (start),
        .result       (result),
        .result_valid (result_valid),
        .root_busy    (root_busy),
        .overflow     (overflow)
    );

    fft_mag_checker checker_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .beat         (beat),
        .start        (start),
        .result       (result),
        .result_valid (result_valid),
        .root_busy    (root_busy),
        .overflow     (overflow),
        .pending      (pending)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic sample_t extreme(input int k);
        case (k % 5)
            0:       return S_MIN;
            1:       return sample_t'(-1);
            2:       return '0;
            3:       return sample_t'(1);
            default: return S_MAX;
        endcase
    endfunction

    function automatic sample_t random_component();
        sample_t     v;
        int unsigned pick;
        pick = $urandom_range(7);
        v    = sample_t'({$urandom(), $urandom()});
        if (pick == 0) begin
            v = extreme($urandom_range(4));
        end else if (pick < 3) begin
            v = v >>> $urandom_range(W - 1);   // smaller magnitudes too
        end
        return v;
    endfunction

    function automatic fft_beat_t make_beat(input int i, input bit extremes);
        fft_beat_t b;
        b.re = random_component();
        b.im = random_component();
        if (extremes && i < 25) begin
            b.re = extreme(i);       // all 25 pairs of extreme values
            b.im = extreme(i / 5);
        end
        b.valid = 1'b1;
        b.sop   = (i == 0);
        b.eop   = (i == LEN - 1);
        return b;
    endfunction

    function automatic fft_beat_t idle_beat();
        fft_beat_t b;
        b.re    = random_component();
        b.im    = random_component();
        b.valid = 1'b0;
        b.sop   = 1'b0;
        b.eop   = 1'b0;
        return b;
    endfunction

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // start_at picks a beat that also carries a start pulse, -1 for none
    task automatic send_frame(input bit extremes, input int start_at);
        int gap;
        for (int i = 0; i < LEN; i++) begin
            if (i > 0 && $urandom_range(3) == 0) begin
                @(posedge clk);
                beat  <= idle_beat();
                start <= 1'b0;
            end
            @(posedge clk);
            beat  <= make_beat(i, extremes);
            start <= (i == start_at);
        end
        gap = $urandom_range(17, 2);
        repeat (gap) begin
            @(posedge clk);
            beat  <= idle_beat();
            start <= 1'b0;
        end
    endtask

    task automatic wait_pending_at_most(input int limit);
        @(negedge clk);
        while (pending > limit) begin
            @(negedge clk);
        end
    endtask

    // all predictions matched, then a quiet window longer than one root
    task automatic wait_drained();
        wait_pending_at_most(0);
        repeat (2 * (W + 2)) @(negedge clk);
        if (root_busy) begin
            checker_i.report_problem("root still busy after the last predicted result");
        end
    endtask

    initial begin
        void'($urandom(32'hb9f1_e3ba));
        rst_n = 1'b0;
        beat  = '0;
        start = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);

        checker_i.begin_test("unarmed_frame");
        send_frame(1'b0, -1);
        wait_drained();
        checker_i.finish_test(0);

        checker_i.begin_test("extreme_components");
        pulse_start();
        send_frame(1'b1, -1);
        wait_drained();
        checker_i.finish_test(HALF);

        checker_i.begin_test("random_with_gaps");
        pulse_start();
        send_frame(1'b0, -1);
        wait_drained();
        checker_i.finish_test(HALF);

        // second pulse lands mid capture, next frame has no start
        checker_i.begin_test("start_during_capture");
        pulse_start();
        send_frame(1'b0, HALF / 4);
        send_frame(1'b0, -1);
        wait_drained();
        checker_i.finish_test(HALF);

        // next capture begins while the root still drains the last one
        checker_i.begin_test("overlapping_captures");
        pulse_start();
        send_frame(1'b0, -1);
        wait_pending_at_most(8);
        pulse_start();
        send_frame(1'b0, -1);
        wait_drained();
        checker_i.finish_test(2 * HALF);

        checker_i.summary(errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* fft_magnitude_unit.f */
+incdir+logic
logic/fft_mag_pkg.sv
logic/bin_power.sv
logic/half_frame_gate.sv
logic/mag_queue.sv
logic/isqrt_seq.sv
logic/fft_magnitude_unit.sv
testbench/fft_mag_checker.sv
testbench/fft_magnitude_unit_tb.sv

/* Bender.yml */
package:
  name: fft_magnitude_unit

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/fft_mag_pkg.sv
      - logic/bin_power.sv
      - logic/half_frame_gate.sv
      - logic/mag_queue.sv
      - logic/isqrt_seq.sv
      - logic/fft_magnitude_unit.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/fft_mag_checker.sv
      - testbench/fft_magnitude_unit_tb.sv
